// ==== Makefile ====
# Verilator build and run for the load-store unit testbench

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Regression passed
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(wildcard src/*.sv src/*.svh test/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation status: pass"; \
	else \
		echo "simulation status: fail"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== build.f ====
+incdir+src
src/lsu_pkg.sv
src/lsu.sv
src/axi_sram.sv
src/mem_subsys_top.sv
test/lsu_checker.sv
test/tb_top.sv

// ==== src/axi_sram.sv ====
`timescale 1ns/10ps
`include "lsu_cfg.svh"

module axi_sram (
  input  logic                     clock,
  input  logic                     reset,
  input  logic [`LSU_XLEN-1:0]     araddr,
  input  logic                     arvalid,
  output logic                     arready,
  output logic [`LSU_XLEN-1:0]     rdata_bus,
  output lsu_pkg::bus_resp_t       rresp,
  output logic                     rvalid,
  input  logic                     rready,
  input  logic [`LSU_XLEN-1:0]     awaddr,
  input  logic                     awvalid,
  output logic                     awready,
  input  logic [`LSU_XLEN-1:0]     wdata_bus,
  input  logic [`LSU_XLEN/8-1:0]   wstrb,
  input  logic                     wvalid,
  output logic                     wready,
  output lsu_pkg::bus_resp_t       bresp,
  output logic                     bvalid,
  input  logic                     bready
);

  localparam int lanes      = `LSU_XLEN / 8;
  localparam int lane_bits  = $clog2(lanes);
  localparam int index_bits = $clog2(`LSU_MEM_WORDS);
  localparam int wait_bits  = $clog2(`LSU_MEM_WAIT + 2);
  localparam int ch_ar      = 0;
  localparam int ch_aw      = 1;
  localparam int ch_w       = 2;

  logic [`LSU_XLEN-1:0]  mem [`LSU_MEM_WORDS];
  logic [2:0]            chan_valid;
  logic [2:0]            chan_ready;
  logic [wait_bits-1:0]  wait_cnt [3];
  logic                  ar_ok;
  logic [index_bits-1:0] ar_index;
  logic                  aw_ok;
  logic                  aw_seen;
  logic                  aw_ok_q;
  logic [index_bits-1:0] aw_index_q;

  initial begin
    for (int i = 0; i < `LSU_MEM_WORDS; i++) begin
      mem[i] = '0; // memory starts cleared
    end
  end

  assign ar_ok    = araddr[`LSU_XLEN-1:lane_bits] < (`LSU_XLEN-lane_bits)'(`LSU_MEM_WORDS);
  assign ar_index = araddr[lane_bits +: index_bits];
  assign aw_ok    = awaddr[`LSU_XLEN-1:lane_bits] < (`LSU_XLEN-lane_bits)'(`LSU_MEM_WORDS);

  // a channel only counts while the slave can take its transfer
  assign chan_valid[ch_ar] = arvalid && !rvalid;
  assign chan_valid[ch_aw] = awvalid && !aw_seen && !bvalid;
  assign chan_valid[ch_w]  = wvalid && aw_seen; // data waits for its address

  assign arready = chan_ready[ch_ar];
  assign awready = chan_ready[ch_aw];
  assign wready  = chan_ready[ch_w];

  always_ff @(posedge clock) begin
    if (reset) begin
      chan_ready <= '0;
      for (int i = 0; i < 3; i++) begin
        wait_cnt[i] <= '0;
      end
    end else begin
      for (int i = 0; i < 3; i++) begin
        if (chan_ready[i]) begin
          chan_ready[i] <= 1'b0; // single-cycle ready, valid is held so it transfers
          wait_cnt[i]   <= '0;
        end else if (chan_valid[i]) begin
          if (wait_cnt[i] == wait_bits'(`LSU_MEM_WAIT)) chan_ready[i] <= 1'b1;
          else wait_cnt[i] <= wait_cnt[i] + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      rvalid  <= 1'b0;
      aw_seen <= 1'b0;
      bvalid  <= 1'b0;
    end else begin
      if (arvalid && arready) rvalid <= 1'b1;
      else if (rready) rvalid <= 1'b0;

      if (awvalid && awready) aw_seen <= 1'b1;
      else if (wvalid && wready) aw_seen <= 1'b0;

      if (wvalid && wready) bvalid <= 1'b1; // response one cycle after data
      else if (bready) bvalid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (arvalid && arready) begin
      rdata_bus <= ar_ok ? mem[ar_index] : '0;
      rresp     <= ar_ok ? lsu_pkg::resp_okay : lsu_pkg::resp_slverr;
    end
    if (awvalid && awready) begin
      aw_ok_q    <= aw_ok;
      aw_index_q <= awaddr[lane_bits +: index_bits];
    end
    if (wvalid && wready) begin
      bresp <= aw_ok_q ? lsu_pkg::resp_okay : lsu_pkg::resp_slverr;
    end
  end

  // byte-strobed write, out-of-range leaves the array alone
  always_ff @(posedge clock) begin
    if (wvalid && wready && aw_ok_q) begin
      for (int i = 0; i < lanes; i++) begin
        if (wstrb[i]) mem[aw_index_q][8*i +: 8] <= wdata_bus[8*i +: 8];
      end
    end
  end

endmodule

// ==== src/lsu.sv ====
`timescale 1ns/10ps
`include "lsu_cfg.svh"

module lsu (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     req,
  input  lsu_pkg::mem_op_t         op,
  input  logic [`LSU_XLEN-1:0]     addr,
  input  logic [`LSU_XLEN-1:0]     wdata,
  output logic [`LSU_XLEN-1:0]     rdata,
  output logic                     read_done,
  output logic                     write_done,
  output logic                     error,
  output logic                     busy,
  output logic [`LSU_XLEN-1:0]     araddr,
  output logic                     arvalid,
  input  logic                     arready,
  input  logic [`LSU_XLEN-1:0]     rdata_bus,
  input  lsu_pkg::bus_resp_t       rresp,
  input  logic                     rvalid,
  output logic                     rready,
  output logic [`LSU_XLEN-1:0]     awaddr,
  output logic                     awvalid,
  input  logic                     awready,
  output logic [`LSU_XLEN-1:0]     wdata_bus,
  output logic [`LSU_XLEN/8-1:0]   wstrb,
  output logic                     wvalid,
  input  logic                     wready,
  input  lsu_pkg::bus_resp_t       bresp,
  input  logic                     bvalid,
  output logic                     bready
);

  localparam int lanes     = `LSU_XLEN / 8;
  localparam int lane_bits = $clog2(lanes);

  lsu_pkg::lsu_state_t     state;
  lsu_pkg::mem_op_t        op_q;
  logic [`LSU_XLEN-1:0]    addr_q;
  logic                    accept;
  logic                    is_load;
  logic                    misaligned;
  logic [`LSU_XLEN-1:0]    store_data;
  logic [lanes-1:0]        store_strb;
  logic [lane_bits-1:0]    offset;
  logic [`LSU_XLEN-1:0]    lane_data;
  logic [`LSU_XLEN-1:0]    load_ext;

  assign accept = req && (state == lsu_pkg::st_idle); // no back-pressure, busy reqs dropped
  assign busy   = (state != lsu_pkg::st_idle);

  // both channels see the same word-aligned address
  assign araddr = {addr_q[`LSU_XLEN-1:lane_bits], {lane_bits{1'b0}}};
  assign awaddr = {addr_q[`LSU_XLEN-1:lane_bits], {lane_bits{1'b0}}};

  always_comb begin
    is_load    = 1'b0;
    misaligned = 1'b0;
    case (op)
      lsu_pkg::op_lb, lsu_pkg::op_lbu: is_load = 1'b1;
      lsu_pkg::op_lh, lsu_pkg::op_lhu: begin
        is_load    = 1'b1;
        misaligned = addr[0];
      end
      lsu_pkg::op_lw: begin
        is_load    = 1'b1;
        misaligned = |addr[lane_bits-1:0];
      end
      lsu_pkg::op_sh: misaligned = addr[0];
      lsu_pkg::op_sw: misaligned = |addr[lane_bits-1:0];
      default: ;
    endcase
  end

  // replicate narrow data into every lane, the strobe picks the live one
  always_comb begin
    case (op)
      lsu_pkg::op_sb: begin
        store_data = {lanes{wdata[7:0]}};
        store_strb = lanes'(1) << addr[lane_bits-1:0];
      end
      lsu_pkg::op_sh: begin
        store_data = {(lanes / 2){wdata[15:0]}};
        store_strb = lanes'(3) << addr[lane_bits-1:0];
      end
      default: begin
        store_data = wdata;
        store_strb = '1;
      end
    endcase
  end

  assign offset    = addr_q[lane_bits-1:0];
  assign lane_data = rdata_bus >> {offset, 3'b000}; // addressed byte down to lane 0

  always_comb begin
    case (op_q)
      lsu_pkg::op_lb:  load_ext = {{(`LSU_XLEN-8){lane_data[7]}}, lane_data[7:0]};
      lsu_pkg::op_lh:  load_ext = {{(`LSU_XLEN-16){lane_data[15]}}, lane_data[15:0]};
      lsu_pkg::op_lbu: load_ext = {{(`LSU_XLEN-8){1'b0}}, lane_data[7:0]};
      lsu_pkg::op_lhu: load_ext = {{(`LSU_XLEN-16){1'b0}}, lane_data[15:0]};
      default:         load_ext = lane_data;
    endcase
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      op_q      <= op;
      addr_q    <= addr;
      wdata_bus <= store_data;
      wstrb     <= store_strb;
    end
    if (state == lsu_pkg::st_rdata && rvalid) begin
      rdata <= load_ext;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state      <= lsu_pkg::st_idle;
      arvalid    <= 1'b0;
      rready     <= 1'b0;
      awvalid    <= 1'b0;
      wvalid     <= 1'b0;
      bready     <= 1'b0;
      read_done  <= 1'b0;
      write_done <= 1'b0;
      error      <= 1'b0;
    end else begin
      case (state)
        lsu_pkg::st_idle: begin
          if (req) begin
            if (misaligned) begin
              state <= lsu_pkg::st_done; // never reaches the bus
            end else if (is_load) begin
              arvalid <= 1'b1;
              state   <= lsu_pkg::st_raddr;
            end else begin
              awvalid <= 1'b1;
              state   <= lsu_pkg::st_waddr;
            end
          end
        end
        lsu_pkg::st_raddr: begin
          if (arready) begin
            arvalid <= 1'b0;
            rready  <= 1'b1;
            state   <= lsu_pkg::st_rdata;
          end
        end
        lsu_pkg::st_rdata: begin
          if (rvalid) begin
            rready <= 1'b0;
            if (rresp != lsu_pkg::resp_okay) error <= 1'b1;
            else read_done <= 1'b1;
            state <= lsu_pkg::st_done;
          end
        end
        lsu_pkg::st_waddr: begin
          if (awready) begin
            awvalid <= 1'b0;
            wvalid  <= 1'b1;
            state   <= lsu_pkg::st_wdata;
          end
        end
        lsu_pkg::st_wdata: begin
          if (wready) begin
            wvalid <= 1'b0;
            bready <= 1'b1;
            state  <= lsu_pkg::st_bresp;
          end
        end
        lsu_pkg::st_bresp: begin
          if (bvalid) begin
            bready <= 1'b0;
            if (bresp != lsu_pkg::resp_okay) error <= 1'b1;
            else write_done <= 1'b1;
            state <= lsu_pkg::st_done;
          end
        end
        lsu_pkg::st_done: begin
          if (read_done || write_done || error) begin
            read_done  <= 1'b0;
            write_done <= 1'b0;
            error      <= 1'b0;
            state      <= lsu_pkg::st_idle;
          end else begin
            // misaligned entry arrives with no pulse pending, raise it now
            error <= 1'b1;
          end
        end
        default: state <= lsu_pkg::st_idle;
      endcase
    end
  end

endmodule

// ==== src/lsu_cfg.svh ====
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// data and address width of the core and the bus
`define LSU_XLEN 32

// slave depth in 32-bit words
`define LSU_MEM_WORDS 1024

// cycles the slave holds off each ready, 0 allowed
`define LSU_MEM_WAIT 2

`endif

// ==== src/lsu_pkg.sv ====
package lsu_pkg;

  typedef enum logic [3:0] {
    op_lb  = 4'd0,
    op_lh  = 4'd1,
    op_lw  = 4'd2,
    op_lbu = 4'd3,
    op_lhu = 4'd4,
    op_sb  = 4'd5,
    op_sh  = 4'd6,
    op_sw  = 4'd7
  } mem_op_t;

  typedef enum logic [2:0] {
    st_idle  = 3'd0,
    st_raddr = 3'd1, // waiting on the read address handshake
    st_rdata = 3'd2,
    st_waddr = 3'd3,
    st_wdata = 3'd4,
    st_bresp = 3'd5,
    st_done  = 3'd6  // completion pulse cycle
  } lsu_state_t;

  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_slverr = 2'b10
  } bus_resp_t;

endpackage

// ==== src/mem_subsys_top.sv ====
`timescale 1ns/10ps
`include "lsu_cfg.svh"

module mem_subsys_top (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 req,
  input  lsu_pkg::mem_op_t     op,
  input  logic [`LSU_XLEN-1:0] addr,
  input  logic [`LSU_XLEN-1:0] wdata,
  output logic [`LSU_XLEN-1:0] rdata,
  output logic                 read_done,
  output logic                 write_done,
  output logic                 error,
  output logic                 busy
);

  // bus between the unit and the memory slave
  logic [`LSU_XLEN-1:0]   araddr;
  logic                   arvalid;
  logic                   arready;
  logic [`LSU_XLEN-1:0]   rdata_bus;
  lsu_pkg::bus_resp_t     rresp;
  logic                   rvalid;
  logic                   rready;
  logic [`LSU_XLEN-1:0]   awaddr;
  logic                   awvalid;
  logic                   awready;
  logic [`LSU_XLEN-1:0]   wdata_bus;
  logic [`LSU_XLEN/8-1:0] wstrb;
  logic                   wvalid;
  logic                   wready;
  lsu_pkg::bus_resp_t     bresp;
  logic                   bvalid;
  logic                   bready;

  lsu u_lsu (
    .clock, .reset, .req, .op, .addr, .wdata,
    .rdata, .read_done, .write_done, .error, .busy,
    .araddr, .arvalid, .arready,
    .rdata_bus, .rresp, .rvalid, .rready,
    .awaddr, .awvalid, .awready,
    .wdata_bus, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready
  );

  axi_sram u_sram (
    .clock, .reset,
    .araddr, .arvalid, .arready,
    .rdata_bus, .rresp, .rvalid, .rready,
    .awaddr, .awvalid, .awready,
    .wdata_bus, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready
  );

endmodule

// ==== test/lsu_checker.sv ====
`timescale 1ns/10ps
`include "lsu_cfg.svh"

module lsu_checker #(
  parameter int req_budget = 32
) (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 req,
  input  lsu_pkg::mem_op_t     op,
  input  logic [`LSU_XLEN-1:0] addr,
  input  logic [`LSU_XLEN-1:0] wdata,
  input  logic [`LSU_XLEN-1:0] rdata,
  input  logic                 read_done,
  input  logic                 write_done,
  input  logic                 error,
  input  logic                 busy,
  input  logic                 report,
  output int                   error_count
);

  localparam int mem_bytes = `LSU_MEM_WORDS * 4;

  logic [7:0]           shadow [mem_bytes];
  logic                 pending = 1'b0;
  lsu_pkg::mem_op_t     p_op;
  logic [`LSU_XLEN-1:0] p_addr;
  logic [`LSU_XLEN-1:0] p_wdata;
  int                   pending_cycles = 0;
  int                   requests = 0;
  int                   loads_compared = 0;
  int                   mismatches = 0;
  int                   failures = 0;
  logic                 summary_done = 1'b0;

  assign error_count = mismatches + failures;

  initial begin
    for (int i = 0; i < mem_bytes; i++) begin
      shadow[i] = 8'h00; // slave starts cleared
    end
  end

  function automatic logic predict_error(input lsu_pkg::mem_op_t o, input logic [31:0] a);
    logic misaligned;
    case (o)
      lsu_pkg::op_lh, lsu_pkg::op_lhu, lsu_pkg::op_sh: misaligned = a[0];
      lsu_pkg::op_lw, lsu_pkg::op_sw: misaligned = (a[1:0] != 2'b00);
      default: misaligned = 1'b0;
    endcase
    return misaligned || (a >= 32'(mem_bytes));
  endfunction

  function automatic logic [31:0] load_ref(input logic [31:0] word, input lsu_pkg::mem_op_t o,
                                           input logic [1:0] low);
    logic [7:0]  b;
    logic [15:0] h;
    case (low)
      2'd0: b = word[7:0];
      2'd1: b = word[15:8];
      2'd2: b = word[23:16];
      default: b = word[31:24];
    endcase
    h = low[1] ? word[31:16] : word[15:0];
    case (o)
      lsu_pkg::op_lb:  return {{24{b[7]}}, b};
      lsu_pkg::op_lh:  return {{16{h[15]}}, h};
      lsu_pkg::op_lbu: return {24'd0, b};
      lsu_pkg::op_lhu: return {16'd0, h};
      default:         return word;
    endcase
  endfunction

  task automatic compare_flag(input string name, input logic expected, input logic actual);
    if (expected !== actual) begin
      $display("mismatch at %0t: %s expected %0h actual %0h", $time, name, expected, actual);
      mismatches++;
    end
  endtask

  task automatic compare_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    if (expected !== actual) begin
      $display("mismatch at %0t: %s expected %h actual %h", $time, name, expected, actual);
      mismatches++;
    end
  endtask

  task automatic apply_store();
    int base;
    base = int'(p_addr);
    shadow[base] = p_wdata[7:0];
    if (p_op != lsu_pkg::op_sb) begin
      shadow[base + 1] = p_wdata[15:8];
    end
    if (p_op == lsu_pkg::op_sw) begin
      shadow[base + 2] = p_wdata[23:16];
      shadow[base + 3] = p_wdata[31:24];
    end
  endtask

  task automatic check_pulse();
    logic        exp_err;
    logic        is_load;
    logic [31:0] word;
    int          base;
    exp_err = predict_error(p_op, p_addr);
    is_load = p_op inside {lsu_pkg::op_lb, lsu_pkg::op_lh, lsu_pkg::op_lw,
                           lsu_pkg::op_lbu, lsu_pkg::op_lhu};
    compare_flag("error", exp_err, error);
    compare_flag("read_done", !exp_err && is_load, read_done);
    compare_flag("write_done", !exp_err && !is_load, write_done);
    if (!exp_err && is_load && read_done) begin
      base = int'({p_addr[31:2], 2'b00});
      word = {shadow[base + 3], shadow[base + 2], shadow[base + 1], shadow[base]};
      compare_word("rdata", load_ref(word, p_op, p_addr[1:0]), rdata);
      loads_compared++;
    end
    if (!exp_err && !is_load && write_done) begin
      apply_store(); // memory only changes on a clean store
    end
    pending = 1'b0;
  endtask

  always @(negedge clock) begin
    if (reset) begin
      if (busy || read_done || write_done || error) begin
        $display("busy or a completion pulse is high during reset at %0t", $time);
        failures++;
      end
    end else if (reset === 1'b0) begin
      if (read_done || write_done || error) begin
        if (pending) begin
          compare_flag("busy", 1'b1, busy); // busy holds through the done cycle
          check_pulse();
        end else begin
          $display("completion pulse at %0t with no request outstanding", $time);
          failures++;
        end
      end else if (pending) begin
        compare_flag("busy", 1'b1, busy);
        pending_cycles++;
        if (pending_cycles > req_budget) begin
          $display("request at address %h got no completion pulse by %0t", p_addr, $time);
          failures++;
          pending = 1'b0;
        end
      end else begin
        compare_flag("busy", 1'b0, busy);
      end
      if (req && !busy) begin
        p_op           = op;
        p_addr         = addr;
        p_wdata        = wdata;
        pending        = 1'b1;
        pending_cycles = 0;
        requests++;
      end
    end
    if (report && !summary_done) begin
      if (pending) begin
        $display("request at address %h still outstanding at the end of the run", p_addr);
        failures++;
      end
      $display("lsu checker: %0d requests, %0d loads compared, %0d mismatches, %0d other errors",
               requests, loads_compared, mismatches, failures);
      summary_done = 1'b1;
    end
  end

endmodule

// ==== test/tb_top.sv ====
`timescale 1ns/10ps
`include "lsu_cfg.svh"

module tb_top;

  localparam int reset_cycles      = 4;
  localparam int directed_requests = 60;
  localparam int random_requests   = 400;
  localparam int req_budget        = 4 * (`LSU_MEM_WAIT + 3) + 8; // three bus phases plus slack
  localparam int mem_bytes         = `LSU_MEM_WORDS * 4;
  localparam int watchdog_cycles   =
    reset_cycles + (directed_requests + random_requests) * (req_budget + 4) + 20;

  logic                 clock;
  logic                 reset;
  logic                 req;
  lsu_pkg::mem_op_t     op;
  logic [`LSU_XLEN-1:0] addr;
  logic [`LSU_XLEN-1:0] wdata;
  logic [`LSU_XLEN-1:0] rdata;
  logic                 read_done;
  logic                 write_done;
  logic                 error;
  logic                 busy;
  logic                 report;
  int                   error_count;
  logic [31:0]          lcg_state = 32'd57;

  mem_subsys_top uut (
    .clock, .reset, .req, .op, .addr, .wdata,
    .rdata, .read_done, .write_done, .error, .busy
  );

  lsu_checker #(.req_budget(req_budget)) lsu_chk (
    .clock, .reset, .req, .op, .addr, .wdata,
    .rdata, .read_done, .write_done, .error, .busy,
    .report, .error_count
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clock);
    $display("watchdog expired after %0d cycles, the run did not finish", watchdog_cycles);
    $display("Regression failed");
    $finish;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic logic [31:0] align_for(input lsu_pkg::mem_op_t o, input logic [31:0] a);
    case (o)
      lsu_pkg::op_lw, lsu_pkg::op_sw: return {a[31:2], 2'b00};
      lsu_pkg::op_lh, lsu_pkg::op_lhu, lsu_pkg::op_sh: return {a[31:1], 1'b0};
      default: return a;
    endcase
  endfunction

  task automatic drive(input lsu_pkg::mem_op_t o, input logic [31:0] a, input logic [31:0] d);
    req   <= 1'b1;
    op    <= o;
    addr  <= a;
    wdata <= d;
  endtask

  task automatic wait_done();
    int waited;
    waited = 0;
    do begin
      @(negedge clock);
      waited++;
    end while (!(read_done || write_done || error) && waited < req_budget);
  endtask

  task automatic issue(input lsu_pkg::mem_op_t o, input logic [31:0] a, input logic [31:0] d);
    @(posedge clock);
    drive(o, a, d);
    @(posedge clock);
    req <= 1'b0;
    wait_done();
  endtask

  // second req lands while the first is in flight and must be dropped
  task automatic issue_while_busy(input lsu_pkg::mem_op_t o1, input logic [31:0] a1,
                                  input lsu_pkg::mem_op_t o2, input logic [31:0] a2,
                                  input logic [31:0] d2);
    @(posedge clock);
    drive(o1, a1, 32'h0);
    @(posedge clock);
    drive(o2, a2, d2);
    @(posedge clock);
    req <= 1'b0;
    wait_done();
  endtask

  initial begin
    logic [31:0]      r;
    logic [31:0]      d;
    logic [31:0]      a;
    lsu_pkg::mem_op_t o;
    reset  <= 1'b1;
    req    <= 1'b0;
    op     <= lsu_pkg::op_lw;
    addr   <= '0;
    wdata  <= '0;
    report <= 1'b0;
    repeat (reset_cycles) @(posedge clock);
    reset <= 1'b0;

    issue(lsu_pkg::op_sw, 32'h10, 32'hdeadbeef);
    issue(lsu_pkg::op_lw, 32'h10, '0);
    for (int k = 0; k < 4; k++) begin
      issue(lsu_pkg::op_sw, 32'h20, 32'h11223344);
      issue(lsu_pkg::op_sb, 32'h20 + k, 32'h000000a0 + k);
      issue(lsu_pkg::op_lw, 32'h20, '0);
    end
    for (int k = 0; k < 2; k++) begin
      issue(lsu_pkg::op_sw, 32'h30, 32'h55667788);
      issue(lsu_pkg::op_sh, 32'h30 + 2 * k, 32'h1234c0de);
      issue(lsu_pkg::op_lw, 32'h30, '0);
    end
    issue(lsu_pkg::op_sw, 32'h40, 32'h80ff7f01); // top bits set and clear per byte
    issue(lsu_pkg::op_sw, 32'h44, 32'h7fff8000);
    for (int k = 0; k < 4; k++) begin
      issue(lsu_pkg::op_lb, 32'h40 + k, '0);
      issue(lsu_pkg::op_lbu, 32'h40 + k, '0);
    end
    for (int k = 0; k < 2; k++) begin
      issue(lsu_pkg::op_lh, 32'h40 + 2 * k, '0);
      issue(lsu_pkg::op_lhu, 32'h40 + 2 * k, '0);
      issue(lsu_pkg::op_lh, 32'h44 + 2 * k, '0);
      issue(lsu_pkg::op_lhu, 32'h44 + 2 * k, '0);
    end
    issue(lsu_pkg::op_sw, 32'h50, 32'ha5a5a5a5);
    issue(lsu_pkg::op_sh, 32'h51, 32'hffffffff);
    issue(lsu_pkg::op_sw, 32'h52, 32'hffffffff);
    issue(lsu_pkg::op_lh, 32'h53, '0);
    issue(lsu_pkg::op_lw, 32'h51, '0);
    issue(lsu_pkg::op_lw, 32'h50, '0);
    issue(lsu_pkg::op_sw, mem_bytes, 32'hcafef00d); // would alias word 0 if decode wrapped
    issue(lsu_pkg::op_sb, mem_bytes + 5, 32'h000000ee);
    issue(lsu_pkg::op_lw, mem_bytes, '0);
    issue(lsu_pkg::op_lbu, 32'hfffffff0, '0);
    issue(lsu_pkg::op_lw, 32'h0, '0);
    issue_while_busy(lsu_pkg::op_lw, 32'h10, lsu_pkg::op_sw, 32'h10, 32'h0badf00d);
    issue(lsu_pkg::op_lw, 32'h10, '0);
    issue_while_busy(lsu_pkg::op_sh, 32'h61, lsu_pkg::op_sw, 32'h60, 32'h0badf00d);
    issue(lsu_pkg::op_lw, 32'h60, '0);

    for (int n = 0; n < random_requests; n++) begin
      r = lcg_next();
      d = lcg_next();
      o = lsu_pkg::mem_op_t'({1'b0, r[18:16]});
      case (r[31:29])
        3'd0: a = mem_bytes + {22'd0, r[9:0]};
        3'd1: a = {24'd0, r[7:0]}; // raw low bits, often misaligned
        3'd2: a = align_for(o, r % mem_bytes);
        default: a = align_for(o, {24'd0, r[7:0]});
      endcase
      issue(o, a, d);
    end

    repeat (5) @(posedge clock);
    report <= 1'b1;
    @(negedge clock);
    @(posedge clock);
    if (error_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule
